// File: Makefile
# Verilator build and run for the iterative multiply/divide unit

VERILATOR  ?= verilator
TOP        ?= tb_imuldiv_iterative
RTL_TOP    ?= imuldiv_iterative
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= Done: no errors

SRCS := $(wildcard hw/*.sv verification/*.sv)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides pass or fail
run: build
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/div_dpath.sv
/*
 * divider datapath: restoring shift-and-subtract on magnitudes,
 * zero-divisor bypass and quotient/remainder sign fix at the output
 */

`default_nettype none
`timescale 1ns/1ps

module div_dpath import imuldiv_pkg::*; #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               step,
  input  muldiv_op_e         op,
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  output logic [2*width-1:0] result
);

  // ----------------------------------------------------------------------
  // operand conditioning
  // ----------------------------------------------------------------------

  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic [width-1:0] a_mag;
  logic [width-1:0] b_mag;

  assign is_signed = (op == op_div);
  assign a_neg = is_signed && a[width-1];
  assign b_neg = is_signed && b[width-1];
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // ----------------------------------------------------------------------
  // restoring division
  // ----------------------------------------------------------------------

  logic [width-1:0] dvsr;
  logic [width-1:0] dvnd;
  logic [width-1:0] rem;
  logic [width-1:0] quo;
  logic             q_neg;
  logic             r_neg;
  logic             div_zero;

  // remainder/quotient pair shifted left by one
  logic [width:0]   rem_sh;
  // two extra bits so the borrow is unambiguous
  logic [width+1:0] diff;
  logic             fits;

  assign rem_sh = {rem, quo[width-1]};
  assign diff   = {1'b0, rem_sh} - {2'b00, dvsr};
  assign fits   = !diff[width+1];

  // divisor and raw dividend, held for the whole operation
  always_ff @(posedge clk) begin
    if (load) begin
      dvsr <= b_mag;
      dvnd <= a;
    end
  end

  // working registers and flags
  always_ff @(posedge clk) begin
    if (reset) begin
      rem      <= '0;
      quo      <= '0;
      q_neg    <= 1'b0;
      r_neg    <= 1'b0;
      div_zero <= 1'b0;
    end else if (load) begin
      rem      <= '0;
      quo      <= a_mag;
      q_neg    <= a_neg ^ b_neg;
      // remainder follows the dividend
      r_neg    <= a_neg;
      div_zero <= (b == '0);
    end else if (step) begin
      // keep the difference only when it did not borrow
      rem <= fits ? diff[width-1:0] : rem_sh[width-1:0];
      quo <= {quo[width-2:0], fits};
    end
  end

  // ----------------------------------------------------------------------
  // sign fix and bypass
  // ----------------------------------------------------------------------

  logic [width-1:0] quo_fix;
  logic [width-1:0] rem_fix;

  // overflow case lands on 2^(width-1) with q_neg clear, so no special path
  assign quo_fix = q_neg ? -quo : quo;
  assign rem_fix = r_neg ? -rem : rem;

  // zero divisor: all-ones quotient, dividend as remainder
  assign result = div_zero ? {dvnd, {width{1'b1}}} : {rem_fix, quo_fix};

endmodule

`default_nettype wire

// File: hw/imuldiv_iterative.sv
/*
 * iterative multiply/divide unit: steers each request to the multiplier
 * or divider, tracks which one owns it and returns its result
 */

`default_nettype none
`timescale 1ns/1ps

module imuldiv_iterative import imuldiv_pkg::*; #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  muldiv_op_e         req_op,
  input  logic [width-1:0]   req_a,
  input  logic [width-1:0]   req_b,
  input  logic               req_val,
  output logic               req_rdy,
  output logic [2*width-1:0] resp_result,
  output logic               resp_val,
  input  logic               resp_rdy
);

  // one iteration per operand bit
  localparam int num_steps = width;

  logic is_mul;
  logic busy;
  // set when the multiplier holds the outstanding operation
  logic owner_mul;
  logic req_go;
  logic resp_go;

  logic mul_req_val;
  logic mul_req_rdy;
  logic mul_resp_val;
  logic mul_resp_rdy;
  logic mul_load;
  logic mul_step;
  logic [2*width-1:0] mul_result;

  logic div_req_val;
  logic div_req_rdy;
  logic div_resp_val;
  logic div_resp_rdy;
  logic div_load;
  logic div_step;
  logic [2*width-1:0] div_result;

  // ----------------------------------------------------------------------
  // request steering
  // ----------------------------------------------------------------------

  assign is_mul = (req_op == op_mul) || (req_op == op_mulu);

  // one operation at a time
  assign req_rdy = !busy && (is_mul ? mul_req_rdy : div_req_rdy);
  assign req_go  = req_val && req_rdy;

  assign mul_req_val = req_val && !busy && is_mul;
  assign div_req_val = req_val && !busy && !is_mul;

  // ----------------------------------------------------------------------
  // response mux
  // ----------------------------------------------------------------------

  assign resp_val    = owner_mul ? mul_resp_val : div_resp_val;
  assign resp_result = owner_mul ? mul_result : div_result;
  assign resp_go     = resp_val && resp_rdy;

  // only the owner sees resp_rdy
  assign mul_resp_rdy = resp_rdy && owner_mul;
  assign div_resp_rdy = resp_rdy && !owner_mul;

  // busy and owner
  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_mul <= 1'b0;
    end else if (req_go) begin
      busy      <= 1'b1;
      owner_mul <= is_mul;
    end else if (resp_go) begin
      busy <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // units
  // ----------------------------------------------------------------------

  iter_ctrl #(.num_steps(num_steps)) i_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .load     (mul_load),
    .step     (mul_step)
  );

  mul_dpath #(.width(width)) i_mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .load   (mul_load),
    .step   (mul_step),
    .op     (req_op),
    .a      (req_a),
    .b      (req_b),
    .result (mul_result)
  );

  iter_ctrl #(.num_steps(num_steps)) i_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .load     (div_load),
    .step     (div_step)
  );

  div_dpath #(.width(width)) i_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .load   (div_load),
    .step   (div_step),
    .op     (req_op),
    .a      (req_a),
    .b      (req_b),
    .result (div_result)
  );

endmodule

`default_nettype wire

// File: hw/imuldiv_pkg.sv
/*
 * shared types for the iterative multiply/divide unit:
 * request opcodes and the control FSM states
 */

`default_nettype none

package imuldiv_pkg;

  // ----------------------------------------------------------------------
  // request opcodes
  // ----------------------------------------------------------------------

  // multiplies return the full double-width product
  // divides return {remainder, quotient}
  typedef enum logic [1:0] {
    // signed multiply
    op_mul  = 2'd0,
    // unsigned multiply
    op_mulu = 2'd1,
    // signed divide
    op_div  = 2'd2,
    // unsigned divide
    op_divu = 2'd3
  } muldiv_op_e;

  // ----------------------------------------------------------------------
  // control FSM states
  // ----------------------------------------------------------------------

  typedef enum logic [1:0] {
    // waiting for a request, ready high
    st_idle = 2'd0,
    // one iteration per cycle
    st_calc = 2'd1,
    // result valid, waiting for resp_rdy
    st_done = 2'd2
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hw/iter_ctrl.sv
/*
 * iteration controller: accepts one request, strobes load and then
 * num_steps step pulses, holds the response until it is taken
 */

`default_nettype none
`timescale 1ns/1ps

module iter_ctrl import imuldiv_pkg::*; #(
  parameter int num_steps = 32
) (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  // counter wide enough to hold num_steps itself
  localparam int cnt_w = $clog2(num_steps + 1);
  localparam logic [cnt_w-1:0] cnt_init = cnt_w'(num_steps);

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic [cnt_w-1:0] count;
  logic cnt_zero;

  // ----------------------------------------------------------------------
  // handshakes and strobes
  // ----------------------------------------------------------------------

  assign cnt_zero = (count == '0);
  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // load on the accepting edge only
  assign load = req_val && req_rdy;
  // steps while counter nonzero, last calc cycle is idle at zero
  assign step = (state == st_calc) && !cnt_zero;

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (load) begin
          state_next = st_calc;
        end
      end
      st_calc: begin
        // counter drained, result settled
        if (cnt_zero) begin
          state_next = st_done;
        end
      end
      st_done: begin
        if (resp_rdy) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // state and down-counter
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      state <= state_next;
      if (load) begin
        count <= cnt_init;
      end else if (step) begin
        count <= count - cnt_w'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/mul_dpath.sv
/*
 * multiplier datapath: shift-and-add on operand magnitudes,
 * product sign applied combinationally at the output
 */

`default_nettype none
`timescale 1ns/1ps

module mul_dpath import imuldiv_pkg::*; #(
  parameter int width = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               load,
  input  logic               step,
  input  muldiv_op_e         op,
  input  logic [width-1:0]   a,
  input  logic [width-1:0]   b,
  output logic [2*width-1:0] result
);

  // ----------------------------------------------------------------------
  // operand conditioning
  // ----------------------------------------------------------------------

  logic is_signed;
  logic a_neg;
  logic b_neg;
  logic [width-1:0] a_mag;
  logic [width-1:0] b_mag;

  // only op_mul looks at the sign bits
  assign is_signed = (op == op_mul);
  assign a_neg = is_signed && a[width-1];
  assign b_neg = is_signed && b[width-1];

  // two's complement magnitude, most negative value maps to 2^(width-1)
  assign a_mag = a_neg ? -a : a;
  assign b_mag = b_neg ? -b : b;

  // ----------------------------------------------------------------------
  // shift-and-add
  // ----------------------------------------------------------------------

  // multiplicand shifts left, multiplier shifts right
  logic [2*width-1:0] mcand;
  logic [width-1:0]   mplier;
  logic [2*width-1:0] prod;
  logic [2*width-1:0] prod_sum;
  logic               add_en;
  logic               prod_neg;

  assign add_en   = step && mplier[0];
  assign prod_sum = prod + mcand;

  // operand shift registers
  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {{width{1'b0}}, a_mag};
      mplier <= b_mag;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // accumulator and product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      prod     <= '0;
      prod_neg <= 1'b0;
    end else if (load) begin
      prod     <= '0;
      prod_neg <= a_neg ^ b_neg;
    end else if (add_en) begin
      prod <= prod_sum;
    end
  end

  // ----------------------------------------------------------------------
  // sign fix
  // ----------------------------------------------------------------------

  // negative product when exactly one signed operand was negative
  assign result = prod_neg ? -prod : prod;

endmodule

`default_nettype wire

// File: sources.f
hw/imuldiv_pkg.sv
hw/iter_ctrl.sv
hw/mul_dpath.sv
hw/div_dpath.sv
hw/imuldiv_iterative.sv
verification/tb_imuldiv_iterative.sv

// File: verification/tb_imuldiv_iterative.sv
/*
 * testbench for the iterative multiply/divide unit with directed and random
 * requests, a reference model and in-order response and timing checks
 */

`default_nettype none
`timescale 1ns/1ps

module tb_imuldiv_iterative import imuldiv_pkg::*; ();

  localparam int width = 32;
  // accept edge to first resp_val is num_steps + 1
  localparam int resp_latency = 33;
  localparam int num_mul_dir = 8;
  localparam int num_div_dir = 10;
  localparam int num_random = 400;
  localparam int num_ops = 2 * num_mul_dir + 2 * num_div_dir + num_random;
  // up to ~45 cycles per op with gaps and back-pressure plus reset margin
  localparam int max_cycles = num_ops * 45 + 500;

  logic clk;
  logic reset;
  muldiv_op_e req_op;
  logic [width-1:0] req_a;
  logic [width-1:0] req_b;
  logic req_val;
  logic req_rdy;
  logic [2*width-1:0] resp_result;
  logic resp_val;
  logic resp_rdy;

  int seed = 87955;
  int cycle = 0;
  logic [63:0] exp_q[$];
  int acc_q[$];
  logic pending = 1'b0;
  logic first_seen = 1'b0;
  logic stall_seen = 1'b0;
  logic [63:0] held_result;
  logic bp_on = 1'b0;
  logic bp_low = 1'b0;
  int bp_left = 0;

  // directed operand pairs
  logic [31:0] mul_a [num_mul_dir] = '{32'h0, 32'h1, 32'hffffffff, 32'h80000000,
                                        32'h80000000, 32'h7fffffff, 32'hfffffff3, 32'h00012345};
  logic [31:0] mul_b [num_mul_dir] = '{32'h7fffffff, 32'hffffffff, 32'hffffffff, 32'h1,
                                        32'h80000000, 32'h7fffffff, 32'h7, 32'hfffedcba};
  // mixed signs, overflow, then zero divisors
  logic [31:0] div_a [num_div_dir] = '{32'h64, 32'hffffff9c, 32'h64, 32'hffffff9c, 32'h80000000,
                                        32'h7fffffff, 32'h5, 32'h7b, 32'hffffff85, 32'h0};
  logic [31:0] div_b [num_div_dir] = '{32'h7, 32'h7, 32'hfffffff9, 32'hfffffff9, 32'hffffffff,
                                        32'h80000000, 32'h9, 32'h0, 32'h0, 32'h0};

  imuldiv_iterative #(.width(width)) i_imuldiv_iterative (
    .clk         (clk),
    .reset       (reset),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------

  // {remainder, quotient} for divides and the full product for multiplies
  function automatic logic [63:0] ref_muldiv(muldiv_op_e op, logic [31:0] a, logic [31:0] b);
    logic signed [63:0] sa64;
    logic signed [63:0] sb64;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    sa = a;
    sb = b;
    sa64 = sa;
    sb64 = sb;
    case (op)
      op_mul:  return sa64 * sb64;
      op_mulu: return {32'h0, a} * {32'h0, b};
      default: begin
        if (b == 32'h0) begin
          return {a, 32'hffffffff};
        end else if (op == op_div && a == 32'h80000000 && b == 32'hffffffff) begin
          return {32'h0, 32'h80000000};
        end else if (op == op_div) begin
          // truncating division where the remainder takes the dividend's sign
          return {32'(sa % sb), 32'(sa / sb)};
        end else begin
          return {a % b, a / b};
        end
      end
    endcase
  endfunction

  task automatic fail_stop(input string what);
    $display("error at cycle %0d: %s", cycle, what);
    $display("Done: errors found");
    $fatal(1, "stopping at first error");
  endtask

  // corners mixed into random operands
  function automatic logic [31:0] rand_operand();
    logic [2:0] sel;
    sel = 3'($random(seed));
    case (sel)
      3'd0: return 32'h0;
      3'd1: return 32'h80000000;
      3'd2: return 32'hffffffff;
      3'd3: return 32'($random(seed)) >> ({$random(seed)} % 32);
      default: return $random(seed);
    endcase
  endfunction

  // one clock with random resp_rdy runs when back-pressure is on
  task automatic next_cycle();
    @(posedge clk);
    if (bp_on) begin
      if (bp_left == 0) begin
        bp_low = ($random(seed) & 3) == 0;
        bp_left = bp_low ? 1 + ({$random(seed)} % 5) : 1 + ({$random(seed)} % 4);
      end
      bp_left = bp_left - 1;
      resp_rdy <= !bp_low;
    end
  endtask

  // hold the request until the DUT takes it
  task automatic send_req(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    req_op <= op;
    req_a <= a;
    req_b <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    req_val <= 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // timeout
  // ----------------------------------------------------------------------

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      fail_stop("timeout, the DUT appears to hang");
    end
  end

  // ----------------------------------------------------------------------
  // checker sampling on the falling edge
  // ----------------------------------------------------------------------

  always @(negedge clk) begin
    if (!reset) begin
      // result frozen while resp_rdy was low
      if (stall_seen) begin
        assert (resp_val) else fail_stop("resp_val dropped under back-pressure");
        assert (resp_result == held_result) else begin
          $display("MISMATCH resp_result held 0x%016h now 0x%016h", held_result, resp_result);
          fail_stop("response changed under back-pressure");
        end
      end
      if (pending) begin
        assert (!req_rdy) else fail_stop("req_rdy high while an operation is outstanding");
      end
      if (resp_val) begin
        assert (exp_q.size() != 0) else fail_stop("resp_val high with nothing outstanding");
        if (!first_seen) begin
          assert (cycle == acc_q[0] + resp_latency) else begin
            $display("accepted at cycle %0d, resp_val rose at %0d", acc_q[0], cycle);
            fail_stop("response latency is wrong");
          end
          first_seen = 1'b1;
        end
        if (resp_rdy) begin
          assert (resp_result == exp_q[0]) else begin
            $display("MISMATCH resp_result expected 0x%016h actual 0x%016h",
                     exp_q[0], resp_result);
            fail_stop("wrong result");
          end
          void'(exp_q.pop_front());
          void'(acc_q.pop_front());
          first_seen = 1'b0;
          pending = 1'b0;
        end
      end
      // transfer happens on the next rising edge
      if (req_val && req_rdy) begin
        exp_q.push_back(ref_muldiv(req_op, req_a, req_b));
        acc_q.push_back(cycle + 1);
        pending = 1'b1;
      end
      stall_seen = resp_val && !resp_rdy;
      held_result = resp_result;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------

  initial begin
    muldiv_op_e op;
    int gap;
    reset = 1'b1;
    req_op = op_mul;
    req_a = '0;
    req_b = '0;
    req_val = 1'b0;
    resp_rdy = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    assert (req_rdy && !resp_val)
      else fail_stop("after reset req_rdy must be high, resp_val low");
    next_cycle();
    for (int i = 0; i < num_mul_dir; i++) begin
      send_req(op_mul, mul_a[i], mul_b[i]);
      send_req(op_mulu, mul_a[i], mul_b[i]);
    end
    for (int i = 0; i < num_div_dir; i++) begin
      send_req(op_div, div_a[i], div_b[i]);
      send_req(op_divu, div_a[i], div_b[i]);
    end
    // random ops with gaps and back-pressure
    bp_on = 1'b1;
    for (int i = 0; i < num_random; i++) begin
      gap = {$random(seed)} % 4;
      repeat (gap) next_cycle();
      op = muldiv_op_e'($random(seed) & 3);
      send_req(op, rand_operand(), rand_operand());
    end
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire
